// File: Makefile
# Verilator build and run for the packet queue system

VERILATOR ?= verilator
TOP       ?= qsys_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator status is not used
run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST OK" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/qsys_credit_if.sv
//////////////////////////////////////////////////
// Admission to buffer link
// Words go forward, credits come back
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface qsys_credit_if
    import qsys_pkg::*;
();

    // Forward path, one admitted word per cycle
    logic       wr_valid;
    qsys_word_t wr_word;

    // Return path, one freed word slot per cycle
    logic       credit_valid;
    qid_t       credit_qid;

    modport admit (
        output wr_valid,
        output wr_word,
        input  credit_valid,
        input  credit_qid
    );

    modport buffer (
        input  wr_valid,
        input  wr_word,
        output credit_valid,
        output credit_qid
    );

endinterface

// File: common/qsys_dequeue_if.sv
//////////////////////////////////////////////////
// Scheduler to buffer link
// Pop requests, head status and returned words
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface qsys_dequeue_if
    import qsys_pkg::*;
();

    // Queue status seen by the scheduler
    qmask_t     pkt_ready;
    logic       head_last;

    // Pop request, one word per cycle
    logic       req_valid;
    qid_t       req_qid;

    // Popped word, one cycle after the request
    logic       rsp_valid;
    qsys_word_t rsp_word;

    modport buffer (
        output pkt_ready,
        output head_last,
        input  req_valid,
        input  req_qid,
        output rsp_valid,
        output rsp_word
    );

    modport sched (
        input  pkt_ready,
        input  head_last,
        output req_valid,
        output req_qid,
        input  rsp_valid,
        input  rsp_word
    );

endinterface

// File: common/qsys_pkg.sv
//////////////////////////////////////////////////
// Queue system types
// Word, queue id, credit and counter types
//////////////////////////////////////////////////

package qsys_pkg;

`include "qsys_settings.svh"

    // Queue number carried with every word
    typedef logic [$clog2(`QSYS_NUM_QUEUES)-1:0] qid_t;

    // Word payload
    typedef logic [`QSYS_DATA_BYTES*8-1:0] data_t;

    // One word as it moves between the blocks
    typedef struct packed {
        data_t data;
        logic  last;
        qid_t  qid;
    } qsys_word_t;

    // Free words of one queue, up to the full depth
    typedef logic [$clog2(`QSYS_QUEUE_DEPTH+1)-1:0] credit_t;

    // Saturating packet counter
    typedef logic [31:0] pkt_count_t;

    // One bit per queue
    typedef logic [`QSYS_NUM_QUEUES-1:0] qmask_t;

endpackage

// File: common/qsys_settings.svh
//////////////////////////////////////////////////
// Queue system sizing
// Queue count, word width, FIFO depth and MTU
//////////////////////////////////////////////////

`ifndef QSYS_SETTINGS_SVH
`define QSYS_SETTINGS_SVH

// Number of per-queue FIFOs
`define QSYS_NUM_QUEUES 4

// Bytes in one packet word
`define QSYS_DATA_BYTES 8

// Words held by each queue FIFO
`define QSYS_QUEUE_DEPTH 64

// Largest packet, in words
`define QSYS_MTU_WORDS 16

`endif

// File: hw/qsys_admission/qsys_admission.sv
//////////////////////////////////////////////////
// Packet admission against per-queue credits
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "qsys_settings.svh"

module qsys_admission
    import qsys_pkg::*;
(
    input  logic  packet_in,
    input  logic  arst_n,
    input  logic  in_valid,
    input  data_t in_data,
    input  logic  in_last,
    input  qid_t  in_qid,
    qsys_credit_if.admit wr
);

    typedef enum logic [1:0] {
        state_idle,
        state_admit,
        state_drop
    } adm_state_t;

    adm_state_t state;
    qid_t       cur_qid;
    credit_t    credit [`QSYS_NUM_QUEUES];

    logic   admit_now;
    logic   fwd;
    qid_t   fwd_qid;
    qmask_t take;
    qmask_t give;

    // Decision is taken once, on the first word
    assign admit_now = credit[in_qid] >= credit_t'(`QSYS_MTU_WORDS);
    assign fwd_qid   = (state == state_idle) ? in_qid : cur_qid;

    always_comb begin
        fwd = 1'b0;
        if (in_valid) begin
            if (state == state_idle) begin
                fwd = admit_now;
            end else begin
                fwd = (state == state_admit);
            end
        end
    end

    // Per-queue spend and refund strobes
    always_comb begin
        for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
            take[q] = fwd && (fwd_qid == qid_t'(q));
            give[q] = wr.credit_valid && (wr.credit_qid == qid_t'(q));
        end
    end

    //////////////////////////////////////////////////
    // Packet state and credit counters

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            state    <= state_idle;
            cur_qid  <= '0;
            wr.wr_valid <= 1'b0;
            for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
                credit[q] <= credit_t'(`QSYS_QUEUE_DEPTH);
            end
        end else begin
            wr.wr_valid <= fwd;
            if (in_valid) begin
                if (state == state_idle) begin
                    cur_qid <= in_qid;
                    if (!in_last) begin
                        state <= admit_now ? state_admit : state_drop;
                    end
                end else if (in_last) begin
                    state <= state_idle;
                end
            end
            // Spend and refund may land on the same queue together
            for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
                credit[q] <= credit[q] - credit_t'(take[q]) + credit_t'(give[q]);
            end
        end
    end

    // Admitted word register
    always_ff @(posedge packet_in) begin
        if (fwd) begin
            wr.wr_word.data <= in_data;
            wr.wr_word.last <= in_last;
            wr.wr_word.qid  <= fwd_qid;
        end
    end

endmodule

// File: hw/qsys_queue_buffer/qsys_queue_buffer.sv
//////////////////////////////////////////////////
// Per-queue FIFO storage for admitted words
// Tracks complete packets and returns credits
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "qsys_settings.svh"

module qsys_queue_buffer
    import qsys_pkg::*;
(
    input  logic packet_in,
    input  logic arst_n,
    qsys_credit_if.buffer  wr,
    qsys_dequeue_if.buffer deq
);

    localparam int ptr_w  = $clog2(`QSYS_QUEUE_DEPTH);
    localparam int cnt_w  = $clog2(`QSYS_QUEUE_DEPTH+1);
    localparam int mem_sz = `QSYS_NUM_QUEUES*`QSYS_QUEUE_DEPTH;

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [cnt_w-1:0] cnt_t;

    // One shared array, queue number in the upper address bits
    qsys_word_t mem [mem_sz];

    ptr_t wr_ptr  [`QSYS_NUM_QUEUES];
    ptr_t rd_ptr  [`QSYS_NUM_QUEUES];
    cnt_t pkt_cnt [`QSYS_NUM_QUEUES];

    qsys_word_t head_word;
    qmask_t     pkt_in;
    qmask_t     pkt_out;
    qmask_t     ready_mask;

    // Head of the queue under request
    assign head_word     = mem[{deq.req_qid, rd_ptr[deq.req_qid]}];
    assign deq.head_last = head_word.last;
    assign deq.pkt_ready = ready_mask;

    always_comb begin
        for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
            pkt_in[q]     = wr.wr_valid && wr.wr_word.last && (wr.wr_word.qid == qid_t'(q));
            pkt_out[q]    = deq.req_valid && head_word.last && (deq.req_qid == qid_t'(q));
            ready_mask[q] = (pkt_cnt[q] != '0);
        end
    end

    //////////////////////////////////////////////////
    // Pointers and complete-packet counts

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
                wr_ptr[q]  <= '0;
                rd_ptr[q]  <= '0;
                pkt_cnt[q] <= '0;
            end
            deq.rsp_valid   <= 1'b0;
            wr.credit_valid <= 1'b0;
        end else begin
            for (int q = 0; q < `QSYS_NUM_QUEUES; q++) begin
                if (wr.wr_valid && (wr.wr_word.qid == qid_t'(q))) begin
                    wr_ptr[q] <= wr_ptr[q] + ptr_t'(1);
                end
                if (deq.req_valid && (deq.req_qid == qid_t'(q))) begin
                    rd_ptr[q] <= rd_ptr[q] + ptr_t'(1);
                end
                pkt_cnt[q] <= pkt_cnt[q] + cnt_t'(pkt_in[q]) - cnt_t'(pkt_out[q]);
            end
            // Every popped word frees one slot
            deq.rsp_valid   <= deq.req_valid;
            wr.credit_valid <= deq.req_valid;
        end
    end

    //////////////////////////////////////////////////
    // Storage and response registers

    always_ff @(posedge packet_in) begin
        if (wr.wr_valid) begin
            mem[{wr.wr_word.qid, wr_ptr[wr.wr_word.qid]}] <= wr.wr_word;
        end
        if (deq.req_valid) begin
            deq.rsp_word  <= head_word;
            wr.credit_qid <= deq.req_qid;
        end
    end

endmodule

// File: hw/qsys_scheduler/qsys_scheduler.sv
//////////////////////////////////////////////////
// Round-robin packet scheduler for one egress
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "qsys_settings.svh"

module qsys_scheduler
    import qsys_pkg::*;
(
    input  logic  packet_in,
    input  logic  arst_n,
    qsys_dequeue_if.sched deq,
    input  logic  out_ready,
    output logic  out_valid,
    output data_t out_data,
    output logic  out_last,
    output qid_t  out_qid
);

    // Queue being drained, also the round-robin reference
    qid_t cur_qid;
    logic in_pkt;

    qid_t pick_qid;
    logic pick_found;
    logic req;

    // Egress back-pressure only holds off new pops
    assign req           = in_pkt && out_ready;
    assign deq.req_valid = req;
    assign deq.req_qid   = cur_qid;

    // Search starts at the queue after the last one served
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_qid   = cur_qid;
        for (int i = 1; i <= `QSYS_NUM_QUEUES; i++) begin
            idx = (int'(cur_qid) + i) % `QSYS_NUM_QUEUES;
            if (!pick_found && deq.pkt_ready[idx]) begin
                pick_found = 1'b1;
                pick_qid   = qid_t'(idx);
            end
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt    <= 1'b0;
            cur_qid   <= qid_t'(`QSYS_NUM_QUEUES-1);
            out_valid <= 1'b0;
        end else begin
            if (!in_pkt) begin
                if (pick_found) begin
                    in_pkt  <= 1'b1;
                    cur_qid <= pick_qid;
                end
            end else if (req && deq.head_last) begin
                // Last word popped, pick again next cycle
                in_pkt <= 1'b0;
            end
            out_valid <= deq.rsp_valid;
        end
    end

    // Egress output register
    always_ff @(posedge packet_in) begin
        if (deq.rsp_valid) begin
            out_data <= deq.rsp_word.data;
            out_last <= deq.rsp_word.last;
            out_qid  <= deq.rsp_word.qid;
        end
    end

endmodule

// File: hw/qsys_top.sv
//////////////////////////////////////////////////
// Packet queue system top level
// Admission, queue buffer, scheduler, counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module qsys_top
    import qsys_pkg::*;
(
    input  logic       packet_in,
    input  logic       arst_n,

    input  logic       in_valid,
    input  data_t      in_data,
    input  logic       in_last,
    input  qid_t       in_qid,

    input  logic       out_ready,
    output logic       out_valid,
    output data_t      out_data,
    output logic       out_last,
    output qid_t       out_qid,

    input  logic       cnt_clear,
    output pkt_count_t in_pkt_cnt,
    output pkt_count_t enq_pkt_cnt,
    output pkt_count_t deq_pkt_cnt
);

    qsys_credit_if  credit_link ();
    qsys_dequeue_if dequeue_link ();

    qsys_admission admission0 (
        .packet_in ( packet_in   ),
        .arst_n    ( arst_n      ),
        .in_valid  ( in_valid    ),
        .in_data   ( in_data     ),
        .in_last   ( in_last     ),
        .in_qid    ( in_qid      ),
        .wr        ( credit_link )
    );

    qsys_queue_buffer buffer0 (
        .packet_in ( packet_in    ),
        .arst_n    ( arst_n       ),
        .wr        ( credit_link  ),
        .deq       ( dequeue_link )
    );

    qsys_scheduler scheduler0 (
        .packet_in ( packet_in    ),
        .arst_n    ( arst_n       ),
        .deq       ( dequeue_link ),
        .out_ready ( out_ready    ),
        .out_valid ( out_valid    ),
        .out_data  ( out_data     ),
        .out_last  ( out_last     ),
        .out_qid   ( out_qid      )
    );

    //////////////////////////////////////////////////
    // Packet counters, saturating, clear wins

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt_cnt  <= '0;
            enq_pkt_cnt <= '0;
            deq_pkt_cnt <= '0;
        end else if (cnt_clear) begin
            in_pkt_cnt  <= '0;
            enq_pkt_cnt <= '0;
            deq_pkt_cnt <= '0;
        end else begin
            if (in_valid && in_last && !(&in_pkt_cnt)) begin
                in_pkt_cnt <= in_pkt_cnt + pkt_count_t'(1);
            end
            // Admitted packets, seen on the forward link
            if (credit_link.wr_valid && credit_link.wr_word.last && !(&enq_pkt_cnt)) begin
                enq_pkt_cnt <= enq_pkt_cnt + pkt_count_t'(1);
            end
            if (out_valid && out_last && !(&deq_pkt_cnt)) begin
                deq_pkt_cnt <= deq_pkt_cnt + pkt_count_t'(1);
            end
        end
    end

endmodule

// File: sources.f
+incdir+common
common/qsys_pkg.sv
common/qsys_credit_if.sv
common/qsys_dequeue_if.sv
hw/qsys_admission/qsys_admission.sv
hw/qsys_queue_buffer/qsys_queue_buffer.sv
hw/qsys_scheduler/qsys_scheduler.sv
hw/qsys_top.sv
verification/qsys_clock_gen.sv
verification/qsys_tb.sv

// File: verification/qsys_clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset source
//////////////////////////////////////////////////

`timescale 1ns/1ps

module qsys_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic packet_in,
    output logic arst_n
);

    initial begin
        packet_in = 1'b0;
        forever begin
            #(period_ns / 2) packet_in = ~packet_in;
        end
    end

    // Release lands on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge packet_in);
        @(negedge packet_in);
        arst_n = 1'b1;
    end

endmodule

// File: verification/qsys_tb.sv
//////////////////////////////////////////////////
// Packet queue system testbench
// Random packets checked against a queue model
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "qsys_settings.svh"

module qsys_tb
    import qsys_pkg::*;
();

    localparam int num_q       = `QSYS_NUM_QUEUES;
    localparam int mtu         = `QSYS_MTU_WORDS;
    localparam int depth       = `QSYS_QUEUE_DEPTH;
    localparam int max_packets = 4 + 8 + depth + 200;
    localparam int wd_cycles   = max_packets * mtu * 20 + 2000;

    logic       packet_in;
    logic       arst_n;
    logic       in_valid;
    data_t      in_data;
    logic       in_last;
    qid_t       in_qid;
    logic       out_ready;
    logic       out_valid;
    data_t      out_data;
    logic       out_last;
    qid_t       out_qid;
    logic       cnt_clear;
    pkt_count_t in_pkt_cnt;
    pkt_count_t enq_pkt_cnt;
    pkt_count_t deq_pkt_cnt;

    // Expected words per queue, read index kept by the compare process
    qsys_word_t exp_mem [num_q][$];
    int         rd_idx [num_q] = '{default: 0};
    int         spent  [num_q] = '{default: 0};
    int         freed  [num_q] = '{default: 0};
    qid_t       order_log [$];
    qid_t       load_order [4] = '{2'd2, 2'd0, 2'd3, 2'd1};

    qid_t cur_q        = '0;
    qid_t last_served  = qid_t'(num_q - 1);
    qid_t forced_qid   = '0;
    int   forced_req   = 0;
    int   forced_ack   = 0;
    logic mid_packet   = 1'b0;
    logic strict_order = 1'b1;
    logic random_ready = 1'b0;
    int   in_total     = 0;
    int   enq_total    = 0;
    int   deq_total    = 0;
    int   word_errors  = 0;
    int   check_errors = 0;
    int   stray_words  = 0;

    qsys_clock_gen #(.period_ns(8), .reset_cycles(10)) clock0 (
        .packet_in ( packet_in ),
        .arst_n    ( arst_n    )
    );

    qsys_top dut0 (
        .packet_in   ( packet_in   ),
        .arst_n      ( arst_n      ),
        .in_valid    ( in_valid    ),
        .in_data     ( in_data     ),
        .in_last     ( in_last     ),
        .in_qid      ( in_qid      ),
        .out_ready   ( out_ready   ),
        .out_valid   ( out_valid   ),
        .out_data    ( out_data    ),
        .out_last    ( out_last    ),
        .out_qid     ( out_qid     ),
        .cnt_clear   ( cnt_clear   ),
        .in_pkt_cnt  ( in_pkt_cnt  ),
        .enq_pkt_cnt ( enq_pkt_cnt ),
        .deq_pkt_cnt ( deq_pkt_cnt )
    );

    //////////////////////////////////////////////////
    // Reference model

    function automatic int pending_words(input qid_t q);
        return exp_mem[q].size() - rd_idx[q];
    endfunction

    // Credit as seen from the output, never above the DUT's own
    function automatic int credit_of(input qid_t q);
        return depth - spent[q] + freed[q];
    endfunction

    // Admission rule, charged for the whole packet at once
    function automatic logic admission_ref(input qid_t q, input int len);
        if (credit_of(q) >= mtu) begin
            spent[q] += len;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic model_empty();
        for (int q = 0; q < num_q; q++) begin
            if (pending_words(qid_t'(q)) != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Next queue with a waiting packet after the last one served
    function automatic qid_t rr_pick(input qid_t last);
        qid_t pick;
        logic found;
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= num_q; i++) begin
            if (!found && pending_words(qid_t'((int'(last) + i) % num_q)) != 0) begin
                found = 1'b1;
                pick  = qid_t'((int'(last) + i) % num_q);
            end
        end
        return pick;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks

    task automatic compare_word(input string name, input qsys_word_t exp,
                                input qsys_word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input pkt_count_t exp,
                                 input pkt_count_t act);
        if (act !== exp) begin
            check_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_qid(input string name, input qid_t exp, input qid_t act);
        if (act !== exp) begin
            check_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers

    task automatic next_cycle();
        @(negedge packet_in);
        if (random_ready) begin
            out_ready = ($urandom_range(0, 3) != 0);
        end
    endtask

    task automatic send_packet(input qid_t q, input int len, input int max_gap);
        qsys_word_t words [$];
        qsys_word_t one;
        int         gap;
        for (int i = 0; i < len; i++) begin
            one.data = {$urandom, $urandom};
            one.last = (i == len - 1);
            one.qid  = q;
            words.push_back(one);
        end
        in_total++;
        // An idle scheduler locks onto the first packet that completes
        if (model_empty() && admission_ref(q, len)) begin
            forced_qid = q;
            forced_req++;
            enq_total++;
            foreach (words[i]) exp_mem[q].push_back(words[i]);
        end else if (!model_empty() && admission_ref(q, len)) begin
            enq_total++;
            foreach (words[i]) exp_mem[q].push_back(words[i]);
        end
        foreach (words[i]) begin
            gap = $urandom_range(0, max_gap);
            repeat (gap) begin
                next_cycle();
                in_valid = 1'b0;
            end
            next_cycle();
            in_valid = 1'b1;
            in_data  = words[i].data;
            in_last  = words[i].last;
            in_qid   = q;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic drain();
        random_ready = 1'b0;
        next_cycle();
        out_ready = 1'b1;
        while (!model_empty()) begin
            next_cycle();
        end
        repeat (8) next_cycle();
    endtask

    //////////////////////////////////////////////////
    // Output compare process

    always @(posedge packet_in) begin
        qsys_word_t act;
        qsys_word_t exp;
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            act.data = out_data;
            act.last = out_last;
            act.qid  = out_qid;
            if (!mid_packet) begin
                if (forced_ack != forced_req) begin
                    cur_q      = forced_qid;
                    forced_ack = forced_req;
                end else if (strict_order) begin
                    cur_q = rr_pick(last_served);
                end else begin
                    cur_q = out_qid;
                end
                order_log.push_back(out_qid);
            end
            if (pending_words(cur_q) == 0) begin
                stray_words++;
                $display("Output word on queue %0d where no packet was expected", out_qid);
                mid_packet = 1'b0;
            end else begin
                exp = exp_mem[cur_q][rd_idx[cur_q]];
                rd_idx[cur_q]++;
                freed[cur_q]++;
                compare_word("out_word", exp, act);
                mid_packet = !exp.last;
                if (exp.last) begin
                    last_served = cur_q;
                    deq_total++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        qid_t q;
        int   len;
        int   order_start;
        void'($urandom(32'h8192_e9d5));
        in_valid  = 1'b0;
        in_data   = '0;
        in_last   = 1'b0;
        in_qid    = '0;
        out_ready = 1'b0;
        cnt_clear = 1'b0;
        wait (arst_n === 1'b1);
        repeat (2) next_cycle();

        // One packet per queue, straight through
        out_ready = 1'b1;
        for (int i = 0; i < num_q; i++) begin
            send_packet(qid_t'(i), $urandom_range(1, mtu), 0);
            drain();
        end

        // Two packets per queue loaded out of order while the egress is stalled
        out_ready   = 1'b0;
        order_start = order_log.size();
        for (int n = 0; n < 2; n++) begin
            foreach (load_order[k]) send_packet(load_order[k], $urandom_range(1, mtu), 0);
        end
        repeat (8) next_cycle();
        drain();
        // Queue 2 completes first, the rest follows round robin
        if (order_log.size() - order_start != 8) begin
            check_errors++;
            $display("Round-robin test drained %0d packets instead of 8",
                     order_log.size() - order_start);
        end else begin
            for (int i = 0; i < 8; i++) begin
                compare_qid("out_qid", qid_t'((2 + i) % num_q), order_log[order_start + i]);
            end
        end

        // Fill queue 0 past its credit, later packets are dropped
        out_ready = 1'b0;
        while (credit_of(qid_t'(0)) >= mtu) begin
            send_packet(qid_t'(0), $urandom_range(1, mtu), 0);
        end
        repeat (3) send_packet(qid_t'(0), $urandom_range(1, mtu), 0);
        repeat (4) next_cycle();
        compare_count("enq_pkt_cnt", pkt_count_t'(enq_total), enq_pkt_cnt);
        drain();

        // Random egress stalls and input gaps, order checked per queue
        strict_order = 1'b0;
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++) begin
            q   = qid_t'($urandom_range(0, num_q - 1));
            len = $urandom_range(1, mtu);
            while (credit_of(q) < mtu) begin
                next_cycle();
            end
            send_packet(q, len, 2);
        end
        drain();
        strict_order = 1'b1;

        // Counter totals, then clear
        compare_count("in_pkt_cnt", pkt_count_t'(in_total), in_pkt_cnt);
        compare_count("enq_pkt_cnt", pkt_count_t'(enq_total), enq_pkt_cnt);
        compare_count("deq_pkt_cnt", pkt_count_t'(deq_total), deq_pkt_cnt);
        cnt_clear = 1'b1;
        next_cycle();
        cnt_clear = 1'b0;
        next_cycle();
        compare_count("in_pkt_cnt", '0, in_pkt_cnt);
        compare_count("enq_pkt_cnt", '0, enq_pkt_cnt);
        compare_count("deq_pkt_cnt", '0, deq_pkt_cnt);

        $display("Errors: %0d word mismatches, %0d check failures, %0d stray words",
                 word_errors, check_errors, stray_words);
        if (word_errors == 0 && check_errors == 0 && stray_words == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (wd_cycles) @(posedge packet_in);
        $display("Watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule
